// File: dv/bs_checker.sv
`timescale 1ns/1ps
`include "bs_consts.svh"

module bs_checker
    import bs_cfg_pkg::*;
    import bs_fixed_pkg::*;
(
    input  logic                 clk,
    input  logic                 nreset,
    input  cmd_t                 cmd,
    input  bs_cfg_t              cfg,
    input  sample_t              sample,
    input  status_t              status,
    input  logic [`BS_SUM_W-1:0] sum,
    input  logic [`BS_SUM_W-1:0] pow_sum,
    output int                   pass_count,
    output int                   fail_count
);

    bs_cfg_t              cfg_frz;
    status_t              prev_status;
    logic [`BS_SUM_W-1:0] exp_sum;
    logic [`BS_SUM_W-1:0] exp_pow;
    longint               pay;
    int                   exp_cnt;
    int                   run_idx;
    int                   run_err;
    logic                 reset_done;
    logic                 clear_pending;
    logic                 in_range;

    // Payoff in 8.15 from the strike rules.
    function automatic longint model_payoff(input bs_cfg_t c,
                                            input logic signed [`BS_G_W-1:0] g,
                                            output logic ok);
        longint kv;
        longint c1v;
        longint prod;
        longint ip;
        kv = longint'(c.k);
        c1v = longint'(c.c1);
        // const2*g is 8.30, integer part by arithmetic shift.
        prod = longint'(g) * longint'(c.c2);
        ip = prod >>> 30;
        ok = 1'b1;
        if (c.c2 == '0) begin
            return (c1v <= kv) ? kv - c1v : 64'sd0;
        end else if (ip >= 5) begin
            return 0;
        end else if (ip < -18) begin
            return kv;
        end
        ok = 1'b0;
        return 0;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
        if (exp_v !== got_v) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp_v, got_v);
            run_err++;
        end
    endtask

    // One line per finished test.
    task automatic close_test(input string what);
        if (run_err == 0) begin
            pass_count++;
            $display("%s: pass", what);
        end else begin
            fail_count++;
            $display("%s: fail with %0d errors", what, run_err);
        end
    endtask

    always @(posedge clk) begin
        if (!nreset) begin
            prev_status = ST_IDLE;
            reset_done = 1'b0;
            clear_pending = 1'b0;
            pass_count = 0;
            fail_count = 0;
            run_idx = 0;
            run_err = 0;
        end else begin
            // First cycle out of reset.
            if (!reset_done) begin
                run_err = 0;
                check_value("status", 64'(ST_IDLE), 64'(status));
                check_value("sum", 64'd0, sum);
                check_value("pow_sum", 64'd0, pow_sum);
                close_test("Reset state");
                reset_done = 1'b1;
            end
            // Sums cleared one cycle into idle.
            if (clear_pending) begin
                check_value("sum", 64'd0, sum);
                check_value("pow_sum", 64'd0, pow_sum);
                close_test($sformatf("Run %0d", run_idx));
                clear_pending = 1'b0;
            end
            case (status)
                ST_IDLE: begin
                    if (prev_status == ST_COMPLETE) begin
                        clear_pending = 1'b1;
                    end
                    if (cmd == CMD_RUN) begin
                        cfg_frz = cfg;
                        exp_sum = '0;
                        exp_pow = '0;
                        exp_cnt = 0;
                        run_err = 0;
                        run_idx++;
                    end
                end
                ST_RUNNING: begin
                    // Only the first niter strobes count.
                    if (sample.valid && longint'(exp_cnt) < longint'(cfg_frz.niter)) begin
                        pay = model_payoff(cfg_frz, sample.g, in_range);
                        if (!in_range) begin
                            $display("Sample %0d of run %0d lies outside the model's ranges",
                                     exp_cnt, run_idx);
                            run_err++;
                        end
                        exp_sum = exp_sum + 64'(pay);
                        exp_pow = exp_pow + 64'((pay * pay) >>> `BS_FRAC);
                        exp_cnt++;
                    end
                end
                ST_COMPLETE: begin
                    if (prev_status != ST_COMPLETE) begin
                        if (longint'(exp_cnt) != longint'(cfg_frz.niter)) begin
                            $display("Run %0d completed after %0d of %0d samples",
                                     run_idx, exp_cnt, cfg_frz.niter);
                            run_err++;
                        end
                        check_value("sum", exp_sum, sum);
                        check_value("pow_sum", exp_pow, pow_sum);
                    end
                end
                default: begin
                    $display("Status holds the unused code %0d", status);
                    run_err++;
                end
            endcase
            prev_status = status;
        end
    end

endmodule

// File: dv/tb_bs_processor.sv
`timescale 1ns/1ps
`include "bs_consts.svh"

module tb_bs_processor
    import bs_cfg_pkg::*;
    import bs_fixed_pkg::*;
();

    localparam int runs = 11;
    // Up to 16 samples at 4 cycles each plus command overhead.
    localparam int cycles_per_test = 16 * 4 + 30;
    localparam int cycle_limit = runs * cycles_per_test;
    localparam int mode_flat = 0;
    localparam int mode_high = 1;
    localparam int mode_low = 2;

    logic                 clk;
    logic                 nreset;
    cmd_t                 cmd;
    bs_cfg_t              cfg;
    sample_t              sample;
    status_t              status;
    logic [`BS_SUM_W-1:0] sum;
    logic [`BS_SUM_W-1:0] pow_sum;
    int                   pass_count;
    int                   fail_count;
    logic [31:0]          lfsr;
    int                   cycles = 0;

    tb_clock_gen u_clock_gen (
        .clk    (clk),
        .nreset (nreset)
    );

    bs_processor UUT (
        .clk     (clk),
        .nreset  (nreset),
        .cmd     (cmd),
        .cfg     (cfg),
        .sample  (sample),
        .status  (status),
        .sum     (sum),
        .pow_sum (pow_sum)
    );

    bs_checker u_checker (
        .clk        (clk),
        .nreset     (nreset),
        .cmd        (cmd),
        .cfg        (cfg),
        .sample     (sample),
        .status     (status),
        .sum        (sum),
        .pow_sum    (pow_sum),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Sample magnitude 5.0 to 15.99, sign picks the class.
    function automatic logic [`BS_G_W-1:0] pick_g(input int mode);
        logic [31:0] ip;
        logic [31:0] fr;
        logic [`BS_G_W-1:0] mag;
        ip = rand_bits(4) % 11;
        fr = rand_bits(15);
        mag = {ip[4:0] + 5'd5, fr[14:0]};
        if (mode == mode_high) begin
            return mag;
        end else if (mode == mode_low) begin
            return -mag;
        end
        fr = rand_bits(20);
        return fr[`BS_G_W-1:0];
    endfunction

    task automatic run_test(input int mode, input int niter, input int extra,
                            input int idle_strobes);
        bs_cfg_t     nc;
        bs_cfg_t     junk;
        logic [31:0] r;
        logic [31:0] d;
        logic [37:0] kk;
        int          gap;
        r = rand_bits(22);
        nc.niter = 32'(niter);
        nc.k = {1'b0, r[21:0]};
        kk = {16'b0, r[21:0]};
        d = rand_bits(16);
        if (mode == mode_flat) begin
            nc.c2 = '0;
            // Strike either side of const1.
            if (rand_bits(1) == 32'd1) begin
                nc.c1 = kk + {22'b0, d[15:0]};
            end else if (kk >= {22'b0, d[15:0]}) begin
                nc.c1 = kk - {22'b0, d[15:0]};
            end else begin
                nc.c1 = '0;
            end
        end else begin
            // 1.0 for the high class, 4.0 for the low one.
            nc.c2 = (mode == mode_high) ? 18'h0_8000 : 18'h2_0000;
            r = rand_bits(22);
            nc.c1 = {16'b0, r[21:0]};
        end
        @(posedge clk);
        cfg <= nc;
        // Strobes while idle.
        for (int i = 0; i < idle_strobes; i++) begin
            @(posedge clk);
            sample.valid <= 1'b1;
            sample.g <= pick_g(mode);
        end
        @(posedge clk);
        sample.valid <= 1'b0;
        cmd <= CMD_RUN;
        @(posedge clk);
        cmd <= CMD_NONE;
        // Garbage config once frozen.
        junk = nc;
        junk.niter = nc.niter + 32'd3;
        junk.k = nc.k ^ 23'h15_5555;
        junk.c1 = nc.c1 ^ 38'h15_5555_5555;
        r = rand_bits(18);
        junk.c2 = r[17:0];
        cfg <= junk;
        for (int i = 0; i < niter + extra; i++) begin
            gap = int'(rand_bits(2));
            repeat (gap) begin
                @(posedge clk);
                sample.valid <= 1'b0;
            end
            @(posedge clk);
            sample.valid <= 1'b1;
            sample.g <= pick_g(mode);
        end
        @(posedge clk);
        sample.valid <= 1'b0;
        while (status != ST_COMPLETE) begin
            @(posedge clk);
        end
        @(posedge clk);
        cmd <= CMD_ACK;
        @(posedge clk);
        cmd <= CMD_NONE;
        while (status != ST_IDLE) begin
            @(posedge clk);
        end
        // Room for the clear check.
        repeat (3) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (nreset) begin
            cycles <= cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("Timeout after %0d cycles, the DUT never finished its run", cycles);
                $display("Test failed");
                $finish;
            end
        end
    end

    initial begin
        cmd = CMD_NONE;
        cfg = '0;
        sample = '0;
        lfsr = 32'd31;
        wait (nreset === 1'b1);
        repeat (2) @(posedge clk);
        for (int t = 0; t < 6; t++) begin
            run_test(mode_flat, int'(rand_bits(4)) + 1, 0, 0);
        end
        run_test(mode_high, int'(rand_bits(4)) + 1, 0, 0);
        run_test(mode_high, int'(rand_bits(4)) + 1, 0, 0);
        run_test(mode_low, int'(rand_bits(4)) + 1, 0, 0);
        run_test(mode_low, int'(rand_bits(4)) + 1, 0, 0);
        // Strobes outside the window are dropped.
        run_test(mode_flat, 10, 4, 3);
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count == runs + 1) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns = 8,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic nreset
);

    // Free-running clock.
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Release on a rising edge so it lines up with the stimulus.
    initial begin
        nreset = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        nreset <= 1'b1;
    end

endmodule

// File: rtl/bs_accumulator.sv
`timescale 1ns/1ps
`include "bs_consts.svh"

module bs_accumulator
    import bs_fixed_pkg::*;
(
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 clear,
    input  payoff_t              payoff,
    output logic [`BS_SUM_W-1:0] sum,
    output logic [`BS_SUM_W-1:0] pow_sum,
    output logic                 sq_done
);

    // Square of the payoff, 16.30.
    logic [`BS_SQ_W-1:0] sq_q;
    logic                sq_vld;

    always_ff @(posedge clk) begin
        sq_q <= payoff.value * payoff.value;
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            sum <= '0;
            pow_sum <= '0;
            sq_vld <= 1'b0;
        end else if (clear) begin
            sum <= '0;
            pow_sum <= '0;
            sq_vld <= 1'b0;
        end else begin
            sq_vld <= payoff.valid;
            if (payoff.valid) begin
                sum <= sum + {{(`BS_SUM_W-`BS_K_W){1'b0}}, payoff.value};
            end
            // Square back to .15 before adding.
            if (sq_vld) begin
                pow_sum <= pow_sum + {{(`BS_SUM_W-`BS_SQ_W+`BS_FRAC){1'b0}},
                                      sq_q[`BS_SQ_W-1:`BS_FRAC]};
            end
        end
    end

    assign sq_done = sq_vld;

endmodule

// File: rtl/bs_cfg_pkg.sv
`include "bs_consts.svh"

package bs_cfg_pkg;

    // One-cycle command strobe, CMD_NONE when quiet.
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_RUN,
        CMD_ACK
    } cmd_t;

    // Core state as seen from outside.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUNNING,
        ST_COMPLETE
    } status_t;

    // Run configuration, 111 bits.
    typedef struct packed {
        // Number of samples to process.
        logic [`BS_NITER_W-1:0]    niter;
        // Strike, 8.15.
        logic signed [`BS_K_W-1:0] k;
        // Drift-scaled spot, 23.15.
        logic [`BS_C1_W-1:0]       c1;
        // Volatility term, 3.15.
        logic [`BS_C2_W-1:0]       c2;
    } bs_cfg_t;

endpackage

// File: rtl/bs_consts.svh
`ifndef BS_CONSTS_SVH
`define BS_CONSTS_SVH

// Configuration field widths.
`define BS_K_W      23
`define BS_C1_W     38
`define BS_C2_W     18
`define BS_G_W      20
`define BS_FRAC     15
`define BS_SUM_W    64
`define BS_NITER_W  32

// Datapath widths.
// const2*g is 8.30, table output 9.31, mantissa 2.15.
`define BS_ARG_W    38
`define BS_LUT_W    40
`define BS_MANT_W   17
`define BS_EXP_W    57
`define BS_SCALED_W 95
// const1*exp product is .61; drop 46 bits to get back to .15.
`define BS_SCALED_SH 46
`define BS_SQ_W     46

// Integer bounds of the table range.
`define BS_CLASS_LO (-18)
`define BS_CLASS_HI 5

`endif

// File: rtl/bs_control.sv
`timescale 1ns/1ps
`include "bs_consts.svh"

module bs_control
    import bs_cfg_pkg::*;
    import bs_fixed_pkg::*;
(
    input  logic    clk,
    input  logic    nreset,
    input  cmd_t    cmd,
    input  bs_cfg_t cfg,
    input  sample_t sample,
    input  logic    sq_done,
    output status_t status,
    output bs_cfg_t cfg_q,
    output sample_t accepted,
    output logic    clear
);

    status_t                state;
    status_t                state_nxt;
    logic [`BS_NITER_W-1:0] acc_cnt;
    logic [`BS_NITER_W-1:0] done_cnt;
    logic [`BS_NITER_W-1:0] done_nxt;
    logic                   take;

    // Pass a strobe only while running and below niter.
    assign take = sample.valid && (state == ST_RUNNING) && (acc_cnt < cfg_q.niter);
    assign accepted.valid = take;
    assign accepted.g = sample.g;

    // Result count including this cycle's square.
    assign done_nxt = done_cnt + {{(`BS_NITER_W-1){1'b0}}, sq_done};

    assign clear = (state == ST_IDLE);
    assign status = state;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (cmd == CMD_RUN) begin
                    state_nxt = ST_RUNNING;
                end
            end
            ST_RUNNING: begin
                // Zero iterations also lands here on the first cycle.
                if (done_nxt == cfg_q.niter) begin
                    state_nxt = ST_COMPLETE;
                end
            end
            ST_COMPLETE: begin
                if (cmd == CMD_ACK) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state <= ST_IDLE;
            acc_cnt <= '0;
            done_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_IDLE) begin
                acc_cnt <= '0;
                done_cnt <= '0;
            end else begin
                acc_cnt <= acc_cnt + {{(`BS_NITER_W-1){1'b0}}, take};
                done_cnt <= done_nxt;
            end
        end
    end

    // Track inputs while idle, hold from the run edge on.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            cfg_q <= cfg;
        end
    end

endmodule

// File: rtl/bs_exp_lut.sv
`timescale 1ns/1ps
`include "bs_consts.svh"

// e^x in 9.31 for x = signed (6,2) index.
// Only indices inside the classified range are filled.
module bs_exp_lut (
    input  logic [7:0]           idx,
    output logic [`BS_LUT_W-1:0] value
);

    always_comb begin
        case (idx)
            // x = 0.00 up to 5.00.
            8'd0:    value = 40'h00_8000_0000;
            8'd1:    value = 40'h00_a45a_f1e1;
            8'd2:    value = 40'h00_d309_4c70;
            8'd3:    value = 40'h01_0ef9_db46;
            8'd4:    value = 40'h01_5bf0_a8b1;
            8'd5:    value = 40'h01_bec3_8edb;
            8'd6:    value = 40'h02_3da7_fcc9;
            8'd7:    value = 40'h02_e096_d20b;
            8'd8:    value = 40'h03_b1cc_971a;
            8'd9:    value = 40'h04_be6e_20bd;
            8'd10:   value = 40'h06_175b_f64c;
            8'd11:   value = 40'h07_d241_c2f6;
            8'd12:   value = 40'h0a_0af2_dfb7;
            8'd13:   value = 40'h0c_e529_dbc0;
            8'd14:   value = 40'h10_8ec7_2139;
            8'd15:   value = 40'h15_42b2_d0a2;
            8'd16:   value = 40'h1b_4c90_2e27;
            8'd17:   value = 40'h23_0d7e_26da;
            8'd18:   value = 40'h2d_0231_5bc3;
            8'd19:   value = 40'h39_cac9_d5db;
            8'd20:   value = 40'h4a_34e2_65c0;
            // x = -21.25 up to -0.25.
            8'd171:  value = 40'h1;
            8'd172:  value = 40'h1;
            8'd173:  value = 40'h2;
            8'd174:  value = 40'h2;
            8'd175:  value = 40'h3;
            8'd176:  value = 40'h4;
            8'd177:  value = 40'h5;
            8'd178:  value = 40'h7;
            8'd179:  value = 40'h9;
            8'd180:  value = 40'hc;
            8'd181:  value = 40'hf;
            8'd182:  value = 40'h13;
            8'd183:  value = 40'h19;
            8'd184:  value = 40'h20;
            8'd185:  value = 40'h29;
            8'd186:  value = 40'h35;
            8'd187:  value = 40'h45;
            8'd188:  value = 40'h58;
            8'd189:  value = 40'h72;
            8'd190:  value = 40'h92;
            8'd191:  value = 40'hbc;
            8'd192:  value = 40'hf1;
            8'd193:  value = 40'h136;
            8'd194:  value = 40'h18e;
            8'd195:  value = 40'h1ff;
            8'd196:  value = 40'h290;
            8'd197:  value = 40'h34b;
            8'd198:  value = 40'h43b;
            8'd199:  value = 40'h56e;
            8'd200:  value = 40'h6f9;
            8'd201:  value = 40'h8f4;
            8'd202:  value = 40'hb80;
            8'd203:  value = 40'hec4;
            8'd204:  value = 40'h12f6;
            8'd205:  value = 40'h1858;
            8'd206:  value = 40'h1f42;
            8'd207:  value = 40'h2823;
            8'd208:  value = 40'h338a;
            8'd209:  value = 40'h422e;
            8'd210:  value = 40'h54fa;
            8'd211:  value = 40'h6d1c;
            8'd212:  value = 40'h8c1a;
            8'd213:  value = 40'hb3e5;
            8'd214:  value = 40'he6fe;
            8'd215:  value = 40'h1_2899;
            8'd216:  value = 40'h1_7cd7;
            8'd217:  value = 40'h1_e902;
            8'd218:  value = 40'h2_73e7;
            8'd219:  value = 40'h3_263e;
            8'd220:  value = 40'h4_0b3c;
            8'd221:  value = 40'h5_3145;
            8'd222:  value = 40'h6_aad0;
            8'd223:  value = 40'h8_8f98;
            8'd224:  value = 40'ha_fe10;
            8'd225:  value = 40'he_1d54;
            8'd226:  value = 40'h12_1f9b;
            8'd227:  value = 40'h17_455f;
            8'd228:  value = 40'h1d_e16b;
            8'd229:  value = 40'h26_5e0c;
            8'd230:  value = 40'h31_43c3;
            8'd231:  value = 40'h3f_41d2;
            8'd232:  value = 40'h51_3947;
            8'd233:  value = 40'h68_4b19;
            8'd234:  value = 40'h85_ea52;
            8'd235:  value = 40'hab_f35f;
            8'd236:  value = 40'hdc_c9ff;
            8'd237:  value = 40'h11b_7fad;
            8'd238:  value = 40'h16c_0504;
            8'd239:  value = 40'h1d3_6911;
            8'd240:  value = 40'h258_2ab7;
            8'd241:  value = 40'h302_a126;
            8'd242:  value = 40'h3dd_8203;
            8'd243:  value = 40'h4f6_8da1;
            8'd244:  value = 40'h65f_6c33;
            8'd245:  value = 40'h82e_c9c4;
            8'd246:  value = 40'ha81_c2e0;
            8'd247:  value = 40'hd7d_b8c7;
            8'd248:  value = 40'h1152_aaa3;
            8'd249:  value = 40'h163e_397e;
            8'd250:  value = 40'h1c8f_8772;
            8'd251:  value = 40'h24ac_306e;
            8'd252:  value = 40'h2f16_ac6c;
            8'd253:  value = 40'h3c76_81d7;
            8'd254:  value = 40'h4da2_cbf1;
            8'd255:  value = 40'h63af_be7a;
            // Never used, the class overrides the result.
            default: value = '0;
        endcase
    end

endmodule

// File: rtl/bs_fixed_pkg.sv
`include "bs_consts.svh"

package bs_fixed_pkg;

    // Gaussian sample, g is 5.15.
    typedef struct packed {
        logic                      valid;
        logic signed [`BS_G_W-1:0] g;
    } sample_t;

    // const2*g read as signed integer plus fraction.
    typedef struct packed {
        logic signed [7:0] int_part;
        logic [29:0]       frac;
    } exp_class_t;

    // Same word read as (6,2) table index and leftover fraction.
    typedef struct packed {
        logic [1:0]  guard;
        logic [7:0]  idx;
        logic [12:0] rem;
        logic [14:0] tail;
    } exp_lut_t;

    typedef union packed {
        exp_class_t class_view;
        exp_lut_t   lut_view;
    } exp_arg_u;

    // Exponent range class.
    typedef enum logic [1:0] {
        RC_HIGH,
        RC_MID,
        RC_LOW
    } range_class_t;

    // Payoff result, value is 8.15.
    typedef struct packed {
        logic                 valid;
        logic [`BS_K_W-1:0]   value;
    } payoff_t;

endpackage

// File: rtl/bs_payoff_pipe.sv
`timescale 1ns/1ps
`include "bs_consts.svh"

module bs_payoff_pipe
    import bs_fixed_pkg::*;
(
    input  logic                      clk,
    input  logic                      nreset,
    input  sample_t                   accepted,
    input  logic signed [`BS_K_W-1:0] k,
    input  logic [`BS_C1_W-1:0]       c1,
    input  logic [`BS_C2_W-1:0]       c2,
    output payoff_t                   payoff
);

    // Valid bit per stage.
    logic [4:0]                  vld;
    logic signed [`BS_ARG_W:0]   arg_full;
    exp_arg_u                    arg_q;
    range_class_t                cls_d;
    range_class_t                cls2;
    range_class_t                cls3;
    logic [`BS_LUT_W-1:0]        lut_value;
    logic [`BS_MANT_W-1:0]       mant;
    logic [`BS_EXP_W-1:0]        exp_q;
    logic [`BS_SCALED_W-1:0]     scaled_q;
    logic                        k_below;
    logic [`BS_K_W-1:0]          sub_d;
    logic [`BS_K_W-1:0]          sub_q;
    logic [`BS_K_W-1:0]          value_q;

    // Stage 1. const2*g, c2 is unsigned so pad a zero sign bit.
    assign arg_full = $signed(accepted.g) * $signed({1'b0, c2});

    // Stage 2. Classify the integer part.
    always_comb begin
        if (arg_q.class_view.int_part >= `BS_CLASS_HI) begin
            cls_d = RC_HIGH;
        end else if (arg_q.class_view.int_part < `BS_CLASS_LO) begin
            cls_d = RC_LOW;
        end else begin
            cls_d = RC_MID;
        end
    end

    bs_exp_lut u_exp_lut (
        .idx   (arg_q.lut_view.idx),
        .value (lut_value)
    );

    // 1 + leftover fraction as 2.15.
    assign mant = {2'b01, 2'b00, arg_q.lut_view.rem};

    // Stage 4. Pick what gets taken off the strike.
    assign k_below = $signed({1'b0, scaled_q[`BS_SCALED_W-1:`BS_SCALED_SH]}) > k;

    always_comb begin
        case (cls3)
            RC_LOW: begin
                // exp underflows, payoff is the full strike.
                sub_d = '0;
            end
            RC_HIGH: begin
                sub_d = k;
            end
            default: begin
                // Clamp at zero payoff.
                if (k_below) begin
                    sub_d = k;
                end else begin
                    sub_d = scaled_q[`BS_SCALED_SH+`BS_K_W-1:`BS_SCALED_SH];
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            vld <= '0;
        end else begin
            vld <= {vld[3:0], accepted.valid};
        end
    end

    always_ff @(posedge clk) begin
        arg_q <= arg_full[`BS_ARG_W-1:0];
        // 9.31 times 2.15 gives 11.46.
        exp_q <= lut_value * mant;
        cls2 <= cls_d;
        // Scaled by const1, 34.61.
        scaled_q <= exp_q * c1;
        cls3 <= cls2;
        sub_q <= sub_d;
        // Stage 5.
        value_q <= k - sub_q;
    end

    assign payoff.valid = vld[4];
    assign payoff.value = value_q;

endmodule

// File: rtl/bs_processor.sv
`timescale 1ns/1ps
`include "bs_consts.svh"

module bs_processor
    import bs_cfg_pkg::*;
    import bs_fixed_pkg::*;
(
    input  logic                 clk,
    input  logic                 nreset,
    input  cmd_t                 cmd,
    input  bs_cfg_t              cfg,
    input  sample_t              sample,
    output status_t              status,
    output logic [`BS_SUM_W-1:0] sum,
    output logic [`BS_SUM_W-1:0] pow_sum
);

    bs_cfg_t cfg_q;
    sample_t accepted;
    payoff_t payoff;
    logic    clear;
    logic    sq_done;

    // Command FSM and sample gating.
    bs_control u_control (
        .clk      (clk),
        .nreset   (nreset),
        .cmd      (cmd),
        .cfg      (cfg),
        .sample   (sample),
        .sq_done  (sq_done),
        .status   (status),
        .cfg_q    (cfg_q),
        .accepted (accepted),
        .clear    (clear)
    );

    // Sample to payoff, five cycles.
    bs_payoff_pipe u_payoff_pipe (
        .clk      (clk),
        .nreset   (nreset),
        .accepted (accepted),
        .k        (cfg_q.k),
        .c1       (cfg_q.c1),
        .c2       (cfg_q.c2),
        .payoff   (payoff)
    );

    bs_accumulator u_accumulator (
        .clk     (clk),
        .nreset  (nreset),
        .clear   (clear),
        .payoff  (payoff),
        .sum     (sum),
        .pow_sum (pow_sum),
        .sq_done (sq_done)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log.
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_bs_processor -f tb.f -o tb_bs_processor
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_bs_processor > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
exit 1

// File: tb.f
+incdir+rtl
rtl/bs_cfg_pkg.sv
rtl/bs_fixed_pkg.sv
rtl/bs_control.sv
rtl/bs_exp_lut.sv
rtl/bs_payoff_pipe.sv
rtl/bs_accumulator.sv
rtl/bs_processor.sv
dv/tb_clock_gen.sv
dv/bs_checker.sv
dv/tb_bs_processor.sv
